/* verilog/cpu_mem_defs.svh */
`ifndef CPU_MEM_DEFS_SVH
`define CPU_MEM_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// word address, byte offset already stripped by the CPU
`define CM_ADDR_W           30
`define CM_DATA_W           32

//////////////////////////////////////////////////////////////////////
// region map, top four bits of the word address
//////////////////////////////////////////////////////////////////////

`define CM_REGION_LOADER    4'hF
`define CM_REGION_CTRL      4'hD
`define CM_REGION_KBD       4'hE
`define CM_REGION_VMEM      4'hC

// sub-field inside the control region that parks the pipeline
`define CM_TRAP_SUB         8'hDD

//////////////////////////////////////////////////////////////////////
// target sizes
//////////////////////////////////////////////////////////////////////

// 2048 words of loader RAM
`define CM_LOADER_AW        11
// text memory is byte addressed
`define CM_VMEM_AW          13
// 8-entry scancode queue
`define CM_KBD_DEPTH_LG     3

// wait-cycle register
`define CM_WAIT_W           4
`define CM_VMEM_WAIT_RST    4'd5

`endif

/* verilog/cpu_mem_pkg.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

package cpu_mem_pkg;

    // plain view, region plus word offset
    typedef struct packed {
        logic [3:0]              region;
        logic [`CM_ADDR_W-5:0]   offset;
    } cm_region_view_s;

    // control region view
    typedef struct packed {
        logic [3:0]   region;
        logic [7:0]   sub;
        logic [15:0]  rsvd;
        logic [1:0]   reg_sel;
    } cm_ctrl_view_s;

    // one data address, decoded either way
    typedef union packed {
        cm_region_view_s  region_view;
        cm_ctrl_view_s    ctrl_view;
    } cm_addr_u;

    // request as issued by the CPU data port
    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [3:0]              be;
        cm_addr_u                addr;
        logic [`CM_DATA_W-1:0]   wdata;
    } cm_req_s;

    // request after decode, lane enable already reversed
    typedef struct packed {
        logic                    sel;
        logic                    read;
        logic                    write;
        logic [3:0]              lane;
        cm_addr_u                addr;
        logic [`CM_DATA_W-1:0]   wdata;
    } cm_bus_s;

    // anything not listed falls through to main memory
    typedef enum logic [3:0] {
        REGION_MAIN   = 4'h0,
        REGION_VMEM   = `CM_REGION_VMEM,
        REGION_CTRL   = `CM_REGION_CTRL,
        REGION_KBD    = `CM_REGION_KBD,
        REGION_LOADER = `CM_REGION_LOADER
    } cm_region_e;

endpackage

`default_nettype wire

/* verilog/region_decoder.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module region_decoder
    import cpu_mem_pkg::*;
(
    input  cm_req_s                   dmem,
    input  logic [`CM_ADDR_W-1:0]     instr_addr,

    output cm_bus_s                   loader_bus,
    output cm_bus_s                   vmem_bus,
    output cm_bus_s                   ctrl_bus,
    output cm_bus_s                   kbd_bus,

    input  logic [`CM_DATA_W-1:0]     loader_rdata,
    input  logic [`CM_DATA_W-1:0]     loader_instr,
    input  logic [`CM_DATA_W-1:0]     ctrl_rdata,
    input  logic [7:0]                kbd_code_out,

    output logic [`CM_DATA_W-1:0]     dmem_rdata,
    output logic [`CM_DATA_W-1:0]     instr_data,
    output logic                      instr_from_loader
);

    cm_region_e   region;
    cm_addr_u     instr_view;
    logic [3:0]   lane;
    cm_bus_s      bus_base;

    assign region     = cm_region_e'(dmem.addr.region_view.region);
    assign instr_view = instr_addr;

    //////////////////////////////////////////////////////////////////////
    // byte lane reversal
    //////////////////////////////////////////////////////////////////////

    // single byte enables mirror, anything else is a full word
    always_comb begin
        case (dmem.be)
            4'b0001: lane = 4'b1000;
            4'b0010: lane = 4'b0100;
            4'b0100: lane = 4'b0010;
            4'b1000: lane = 4'b0001;
            default: lane = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // per-target buses
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bus_base.sel   = 1'b0;
        bus_base.read  = dmem.read;
        bus_base.write = dmem.write;
        bus_base.lane  = lane;
        bus_base.addr  = dmem.addr;
        bus_base.wdata = dmem.wdata;

        loader_bus     = bus_base;
        vmem_bus       = bus_base;
        ctrl_bus       = bus_base;
        kbd_bus        = bus_base;

        // only the addressed target sees sel
        loader_bus.sel = (region == REGION_LOADER);
        vmem_bus.sel   = (region == REGION_VMEM);
        ctrl_bus.sel   = (region == REGION_CTRL);
        kbd_bus.sel    = (region == REGION_KBD);
    end

    //////////////////////////////////////////////////////////////////////
    // read data return
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (region)
            REGION_LOADER: dmem_rdata = loader_rdata;
            REGION_CTRL:   dmem_rdata = ctrl_rdata;
            REGION_KBD:    dmem_rdata = {{(`CM_DATA_W-8){1'b0}}, kbd_code_out};
            // main memory, flash and text memory read as zero
            default:       dmem_rdata = '0;
        endcase
    end

    // instruction fetch only maps the loader
    assign instr_from_loader = (instr_view.region_view.region == `CM_REGION_LOADER);
    assign instr_data        = instr_from_loader ? loader_instr : '0;

endmodule

`default_nettype wire

/* verilog/loader_ram.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module loader_ram
    import cpu_mem_pkg::*;
(
    input  logic                      clk_pipeline,
    input  cm_bus_s                   bus,
    input  logic [`CM_ADDR_W-1:0]     instr_addr,
    input  logic                      instr_en,
    output logic [`CM_DATA_W-1:0]     rdata,
    output logic [`CM_DATA_W-1:0]     instr_rdata
);

    localparam int WORDS = 1 << `CM_LOADER_AW;

    logic [`CM_DATA_W-1:0]      ram [0:WORDS-1];
    logic [`CM_LOADER_AW-1:0]   data_addr;
    logic [`CM_LOADER_AW-1:0]   fetch_addr;

    assign data_addr  = bus.addr.region_view.offset[`CM_LOADER_AW-1:0];
    assign fetch_addr = instr_addr[`CM_LOADER_AW-1:0];

    // data port, lane bit 3 is the low byte
    always_ff @(posedge clk_pipeline) begin
        if (bus.sel) begin
            rdata <= ram[data_addr];
            if (bus.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.lane[3-b]) begin
                        ram[data_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // instruction port, read only
    always_ff @(posedge clk_pipeline) begin
        if (instr_en) begin
            instr_rdata <= ram[fetch_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/text_mem_writer.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module text_mem_writer
    import cpu_mem_pkg::*;
(
    input  logic                      clk_pipeline,
    input  logic                      rst,
    input  cm_bus_s                   bus,
    input  logic [`CM_WAIT_W-1:0]     wait_cycles,
    output logic                      busy,
    input  logic [`CM_VMEM_AW-1:0]    disp_addr,
    output logic [7:0]                disp_char
);

    // one extra bit so wait+3 fits
    localparam int CNT_W = `CM_WAIT_W + 1;

    logic [7:0]               char_mem [0:(1 << `CM_VMEM_AW)-1];
    logic                     active;
    logic [CNT_W-1:0]         stall_cnt;
    logic [CNT_W-1:0]         stall_last;
    logic [1:0]               lane_idx;
    logic [`CM_VMEM_AW-1:0]   wr_addr;
    logic [7:0]               wr_char;

    assign active     = bus.sel & bus.write;
    assign stall_last = {1'b0, wait_cycles} + CNT_W'(2);

    // lane 1000 is byte 0, lane 0001 is byte 3
    always_comb begin
        case (bus.lane)
            4'b1000: lane_idx = 2'd0;
            4'b0100: lane_idx = 2'd1;
            4'b0010: lane_idx = 2'd2;
            default: lane_idx = 2'd3;
        endcase
    end

    assign wr_addr = {bus.addr.region_view.offset[`CM_VMEM_AW-3:0], lane_idx};
    assign wr_char = bus.wdata[8*lane_idx +: 8];

    //////////////////////////////////////////////////////////////////////
    // stall counter
    //////////////////////////////////////////////////////////////////////

    // counts up through the stall, then spins until the CPU lets go
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            stall_cnt <= '0;
        end else if (!active) begin
            stall_cnt <= '0;
        end else if (stall_cnt <= stall_last) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // high for wait+3 cycles from the first held cycle
    assign busy = active && (stall_cnt <= stall_last);

    // store on the first cycle, request is stable from then on
    always_ff @(posedge clk_pipeline) begin
        if (active && stall_cnt == '0) begin
            char_mem[wr_addr] <= wr_char;
        end
    end

    assign disp_char = char_mem[disp_addr];

endmodule

`default_nettype wire

/* verilog/io_ctrl_regs.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module io_ctrl_regs
    import cpu_mem_pkg::*;
(
    input  logic                          clk_pipeline,
    input  logic                          rst,
    input  cm_bus_s                       bus,
    input  logic [`CM_KBD_DEPTH_LG:0]     kbd_count,
    output logic [`CM_DATA_W-1:0]         rdata,
    output logic [`CM_WAIT_W-1:0]         wait_cycles,
    output logic                          trap_stall
);

    logic                     access;
    logic                     trap_hit;
    logic [1:0]               reg_sel;
    logic [`CM_WAIT_W-1:0]    wait_reg;

    assign access   = bus.sel & (bus.read | bus.write);
    assign trap_hit = (bus.addr.ctrl_view.sub == `CM_TRAP_SUB);
    assign reg_sel  = bus.addr.ctrl_view.reg_sel;

    // trap window holds the pipeline as long as the access stays up
    assign trap_stall = access & trap_hit;

    // register 0, text memory wait cycles
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wait_reg <= `CM_VMEM_WAIT_RST;
        end else if (bus.sel && bus.write && !trap_hit && reg_sel == 2'd0) begin
            wait_reg <= bus.wdata[`CM_WAIT_W-1:0];
        end
    end

    assign wait_cycles = wait_reg;

    // read side, register 1 is the queue fill level
    always_comb begin
        rdata = '0;
        if (!trap_hit) begin
            case (reg_sel)
                2'd0:    rdata = {{(`CM_DATA_W-`CM_WAIT_W){1'b0}}, wait_reg};
                2'd1:    rdata = {{(`CM_DATA_W-`CM_KBD_DEPTH_LG-1){1'b0}}, kbd_count};
                default: rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/scancode_queue.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module scancode_queue
    import cpu_mem_pkg::*;
(
    input  logic                          clk_pipeline,
    input  logic                          rst,
    input  cm_bus_s                       bus,
    input  logic                          push_valid,
    input  logic [7:0]                    push_code,
    output logic [7:0]                    code,
    output logic                          ready,
    output logic                          overflow,
    output logic [`CM_KBD_DEPTH_LG:0]     count,
    output logic                          read_stall
);

    localparam int DEPTH = 1 << `CM_KBD_DEPTH_LG;

    logic [7:0]                   fifo_mem [0:DEPTH-1];
    logic [`CM_KBD_DEPTH_LG-1:0]  wr_ptr;
    logic [`CM_KBD_DEPTH_LG-1:0]  rd_ptr;
    logic [`CM_KBD_DEPTH_LG:0]    fill;
    logic                         empty;
    logic                         full;
    logic                         rd_req;
    logic                         do_pop;
    logic                         do_push;

    assign empty   = (fill == '0);
    assign full    = fill[`CM_KBD_DEPTH_LG];
    assign rd_req  = bus.sel & bus.read;
    assign do_pop  = rd_req & ~empty;
    assign do_push = push_valid & ~full;

    // CPU waits here until a code shows up
    assign read_stall = rd_req & empty;

    //////////////////////////////////////////////////////////////////////
    // pointers and flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // sticky, no way to push back on the source
            if (push_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= push_code;
        end
    end

    assign code  = fifo_mem[rd_ptr];
    assign ready = ~empty;
    assign count = fill;

endmodule

`default_nettype wire

/* verilog/cpu_mem_interface.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module cpu_mem_interface
    import cpu_mem_pkg::*;
(
    input  logic                          clk_pipeline,
    input  logic                          rst,

    // CPU data port
    input  cm_req_s                       dmem,
    output logic [`CM_DATA_W-1:0]         dmem_rdata,

    // CPU instruction port
    input  logic [`CM_ADDR_W-1:0]         instr_addr,
    output logic [`CM_DATA_W-1:0]         instr_data,

    // keyboard source
    input  logic                          kbd_valid,
    input  logic [7:0]                    kbd_code,
    output logic                          kbd_ready,
    output logic                          kbd_overflow,

    // display read port
    input  logic [`CM_VMEM_AW-1:0]        disp_addr,
    output logic [7:0]                    disp_char,

    output logic                          mem_stall
);

    //////////////////////////////////////////////////////////////////////
    // target buses and return paths
    //////////////////////////////////////////////////////////////////////

    cm_bus_s                      loader_bus;
    cm_bus_s                      vmem_bus;
    cm_bus_s                      ctrl_bus;
    cm_bus_s                      kbd_bus;

    logic [`CM_DATA_W-1:0]        loader_rdata;
    logic [`CM_DATA_W-1:0]        loader_instr;
    logic [`CM_DATA_W-1:0]        ctrl_rdata;
    logic [7:0]                   kbd_head;
    logic                         instr_from_loader;

    logic [`CM_WAIT_W-1:0]        wait_cycles;
    logic [`CM_KBD_DEPTH_LG:0]    kbd_count;

    // stall sources
    logic                         vmem_busy;
    logic                         kbd_stall;
    logic                         trap_stall;

    region_decoder u_decoder (
        .dmem              (dmem),
        .instr_addr        (instr_addr),
        .loader_bus        (loader_bus),
        .vmem_bus          (vmem_bus),
        .ctrl_bus          (ctrl_bus),
        .kbd_bus           (kbd_bus),
        .loader_rdata      (loader_rdata),
        .loader_instr      (loader_instr),
        .ctrl_rdata        (ctrl_rdata),
        .kbd_code_out      (kbd_head),
        .dmem_rdata        (dmem_rdata),
        .instr_data        (instr_data),
        .instr_from_loader (instr_from_loader)
    );

    loader_ram u_loader (
        .clk_pipeline (clk_pipeline),
        .bus          (loader_bus),
        .instr_addr   (instr_addr),
        .instr_en     (instr_from_loader),
        .rdata        (loader_rdata),
        .instr_rdata  (loader_instr)
    );

    text_mem_writer u_vmem (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .bus          (vmem_bus),
        .wait_cycles  (wait_cycles),
        .busy         (vmem_busy),
        .disp_addr    (disp_addr),
        .disp_char    (disp_char)
    );

    io_ctrl_regs u_ctrl (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .bus          (ctrl_bus),
        .kbd_count    (kbd_count),
        .rdata        (ctrl_rdata),
        .wait_cycles  (wait_cycles),
        .trap_stall   (trap_stall)
    );

    scancode_queue u_kbd (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .bus          (kbd_bus),
        .push_valid   (kbd_valid),
        .push_code    (kbd_code),
        .code         (kbd_head),
        .ready        (kbd_ready),
        .overflow     (kbd_overflow),
        .count        (kbd_count),
        .read_stall   (kbd_stall)
    );

    // main memory and flash never stall
    assign mem_stall = vmem_busy | kbd_stall | trap_stall;

endmodule

`default_nettype wire

/* testbench/tb_cpu_mem_interface.sv */
`default_nettype none

`include "cpu_mem_defs.svh"

module tb_cpu_mem_interface
    import cpu_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NO_PUSH = 255;

    typedef enum logic [2:0] {
        OP_ACCESS,
        OP_LATE,
        OP_FETCH,
        OP_DISP,
        OP_PUSH,
        OP_FLAGS,
        OP_TRAP
    } op_e;

    // one table row
    typedef struct packed {
        op_e                     op;
        cm_req_s                 req;
        logic [31:0]             aux;
        logic [31:0]             exp_data;
        logic                    chk_data;
        logic [7:0]              exp_stall;
        logic [7:0]              push_at;
    } step_s;

    logic                        clk_pipeline;
    logic                        rst;
    cm_req_s                     dmem;
    logic [`CM_DATA_W-1:0]       dmem_rdata;
    logic [`CM_ADDR_W-1:0]       instr_addr;
    logic [`CM_DATA_W-1:0]       instr_data;
    logic                        kbd_valid;
    logic [7:0]                  kbd_code;
    logic                        kbd_ready;
    logic                        kbd_overflow;
    logic [`CM_VMEM_AW-1:0]      disp_addr;
    logic [7:0]                  disp_char;
    logic                        mem_stall;

    step_s                       steps [$];
    string                       names [$];
    int                          n_checks;
    int                          n_errors;
    int                          cycle_limit;
    int                          cycle_count;

    cpu_mem_interface uut (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .dmem         (dmem),
        .dmem_rdata   (dmem_rdata),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .kbd_valid    (kbd_valid),
        .kbd_code     (kbd_code),
        .kbd_ready    (kbd_ready),
        .kbd_overflow (kbd_overflow),
        .disp_addr    (disp_addr),
        .disp_char    (disp_char),
        .mem_stall    (mem_stall)
    );

    initial begin
        clk_pipeline = 1'b0;
        forever #20 clk_pipeline = ~clk_pipeline;
    end

    //////////////////////////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////////////////////////

    // CPU enable bit k ends up on data byte k once mirrored and mapped
    function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
                                               input logic [31:0] wdata,
                                               input logic [3:0]  be);
        logic [31:0] res;
        res = old_word;
        case (be)
            4'b0001: res[7:0]   = wdata[7:0];
            4'b0010: res[15:8]  = wdata[15:8];
            4'b0100: res[23:16] = wdata[23:16];
            4'b1000: res[31:24] = wdata[31:24];
            default: res        = wdata;
        endcase
        return res;
    endfunction

    // text memory byte index within the word
    function automatic logic [1:0] text_index(input logic [3:0] be);
        case (be)
            4'b0001: return 2'd0;
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic cm_req_s make_req(input logic        rd,
                                         input logic        wr,
                                         input logic [3:0]  be,
                                         input logic [29:0] addr,
                                         input logic [31:0] wdata);
        cm_req_s r;
        r.read  = rd;
        r.write = wr;
        r.be    = be;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // table construction
    //////////////////////////////////////////////////////////////////////

    task automatic add_step(input string       name,
                            input op_e         op,
                            input cm_req_s     req,
                            input logic [31:0] aux,
                            input logic [31:0] exp_data,
                            input logic        chk,
                            input int          stalls,
                            input int          push_at);
        step_s s;
        s.op        = op;
        s.req       = req;
        s.aux       = aux;
        s.exp_data  = exp_data;
        s.chk_data  = chk;
        s.exp_stall = stalls[7:0];
        s.push_at   = push_at[7:0];
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic add_write(input string name, input logic [29:0] addr,
                             input logic [3:0] be, input logic [31:0] wdata,
                             input int stalls);
        add_step(name, OP_ACCESS, make_req(1'b0, 1'b1, be, addr, wdata),
                 32'h0, 32'h0, 1'b0, stalls, NO_PUSH);
    endtask

    task automatic add_read(input string name, input logic [29:0] addr,
                            input logic [31:0] exp_data, input int stalls);
        add_step(name, OP_ACCESS, make_req(1'b1, 1'b0, 4'b1111, addr, 32'h0),
                 32'h0, exp_data, 1'b1, stalls, NO_PUSH);
    endtask

    // steps without a data request
    task automatic add_probe(input string name, input op_e op,
                             input logic [31:0] aux, input logic [31:0] exp_data);
        add_step(name, op, '0, aux, exp_data, 1'b1, 0, NO_PUSH);
    endtask

    task automatic build_table();
        logic [29:0] ld_a;
        logic [29:0] ld_b;
        logic [29:0] ctrl_wait;
        logic [29:0] ctrl_fill;
        logic [29:0] kbd_addr;
        logic [29:0] txt_addr;
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] d;
        logic [3:0]  be;
        logic [7:0]  codes [0:12];
        ld_a      = {`CM_REGION_LOADER, 26'h010};
        ld_b      = {`CM_REGION_LOADER, 26'h7FF};
        ctrl_wait = {`CM_REGION_CTRL, 8'h00, 16'h0, 2'd0};
        ctrl_fill = {`CM_REGION_CTRL, 8'h00, 16'h0, 2'd1};
        kbd_addr  = {`CM_REGION_KBD, 26'h0};
        for (int k = 0; k < 13; k++) begin
            codes[k] = 8'($urandom);
        end

        add_probe("reset flags", OP_FLAGS, 32'h0, 32'h0);
        add_read("wait reg reset", ctrl_wait, 32'd5, 0);

        // loader byte lanes
        word_a = $urandom;
        add_write("loader a full", ld_a, 4'b1111, word_a, 0);
        for (int k = 0; k < 4; k++) begin
            be     = 4'b0001 << k;
            d      = $urandom;
            word_a = lane_merge(word_a, d, be);
            add_write($sformatf("loader a be %b", be), ld_a, be, d, 0);
        end
        add_step("loader a read", OP_LATE, make_req(1'b1, 1'b0, 4'b1111, ld_a, 32'h0),
                 32'h0, word_a, 1'b1, 0, NO_PUSH);
        add_probe("loader a fetch", OP_FETCH, 32'(ld_a), word_a);
        word_b = $urandom;
        add_write("loader b full", ld_b, 4'b1111, word_b, 0);
        d      = $urandom;
        word_b = lane_merge(word_b, d, 4'b0110);
        add_write("loader b be 0110", ld_b, 4'b0110, d, 0);
        add_step("loader b read", OP_LATE, make_req(1'b1, 1'b0, 4'b1111, ld_b, 32'h0),
                 32'h0, word_b, 1'b1, 0, NO_PUSH);
        add_probe("loader b fetch", OP_FETCH, 32'(ld_b), word_b);

        // text memory with the reset wait count
        txt_addr = {`CM_REGION_VMEM, 26'h025};
        d        = $urandom;
        add_write("text write wait 5", txt_addr, 4'b0100, d, 8);
        add_probe("text char 1", OP_DISP, 32'({11'h025, text_index(4'b0100)}),
                  32'(d[8*text_index(4'b0100) +: 8]));

        // wait count of 2
        add_write("wait reg write", ctrl_wait, 4'b1111, 32'd2, 0);
        add_read("wait reg readback", ctrl_wait, 32'd2, 0);
        txt_addr = {`CM_REGION_VMEM, 26'h03A};
        d        = $urandom;
        add_write("text write wait 2", txt_addr, 4'b1000, d, 5);
        add_probe("text char 2", OP_DISP, 32'({11'h03A, text_index(4'b1000)}),
                  32'(d[8*text_index(4'b1000) +: 8]));

        // keyboard queue order
        for (int k = 0; k < 3; k++) begin
            add_probe($sformatf("kbd push %0d", k), OP_PUSH, 32'(codes[k]), 32'h0);
        end
        add_probe("kbd ready", OP_FLAGS, 32'h0, 32'b001);
        add_read("kbd fill 3", ctrl_fill, 32'd3, 0);
        for (int k = 0; k < 3; k++) begin
            add_read($sformatf("kbd pop %0d", k), kbd_addr, 32'(codes[k]), 0);
        end
        add_probe("kbd drained", OP_FLAGS, 32'h0, 32'b000);

        // read on an empty queue waits for the push in its fourth cycle
        add_step("kbd empty read", OP_ACCESS, make_req(1'b1, 1'b0, 4'b1111, kbd_addr, 32'h0),
                 32'(codes[3]), 32'(codes[3]), 1'b1, 4, 3);

        // overflow
        for (int k = 4; k < 13; k++) begin
            add_probe($sformatf("kbd fill push %0d", k), OP_PUSH, 32'(codes[k]), 32'h0);
        end
        add_probe("kbd overflow", OP_FLAGS, 32'h0, 32'b011);
        add_read("kbd fill 8", ctrl_fill, 32'd8, 0);
        for (int k = 4; k < 12; k++) begin
            add_read($sformatf("kbd full pop %0d", k), kbd_addr, 32'(codes[k]), 0);
        end
        add_probe("kbd empty sticky", OP_FLAGS, 32'h0, 32'b010);

        // trap window and unmapped regions
        add_step("trap hold", OP_TRAP,
                 make_req(1'b1, 1'b0, 4'b1111, {`CM_REGION_CTRL, `CM_TRAP_SUB, 18'h0}, 32'h0),
                 32'd10, 32'h0, 1'b0, 0, NO_PUSH);
        add_read("main memory read", {4'h0, 26'h1234}, 32'h0, 0);
        add_read("region b read", {4'hB, 26'h0040}, 32'h0, 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking and step execution
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        n_checks++;
        assert (act_val === exp_val) else begin
            n_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    // inputs change 2 ns after a rising edge, outputs are read at the falling edge
    task automatic run_step(input string name, input step_s s);
        int          stalls;
        int          cyc;
        bit          done;
        logic [31:0] got;
        stalls = 0;
        cyc    = 0;
        done   = 1'b0;
        got    = '0;
        case (s.op)
            OP_ACCESS, OP_LATE: begin
                dmem     = s.req;
                kbd_code = s.aux[7:0];
                while (!done) begin
                    kbd_valid = (cyc == int'(s.push_at));
                    @(negedge clk_pipeline);
                    if (mem_stall) begin
                        stalls++;
                    end else begin
                        done = 1'b1;
                        got  = dmem_rdata;
                    end
                    @(posedge clk_pipeline);
                    #2;
                    cyc++;
                end
                kbd_valid = 1'b0;
                // registered read data shows up one cycle later
                if (s.op == OP_LATE) begin
                    @(negedge clk_pipeline);
                    got = dmem_rdata;
                    @(posedge clk_pipeline);
                    #2;
                end
                check_value({name, " stall cycles"}, 32'(s.exp_stall), 32'(stalls));
                if (s.chk_data) begin
                    check_value({name, " data"}, s.exp_data, got);
                end
                dmem = '0;
                @(posedge clk_pipeline);
                #2;
            end
            OP_FETCH: begin
                instr_addr = s.aux[`CM_ADDR_W-1:0];
                @(posedge clk_pipeline);
                @(negedge clk_pipeline);
                check_value({name, " instr"}, s.exp_data, instr_data);
                @(posedge clk_pipeline);
                #2;
            end
            OP_DISP: begin
                disp_addr = s.aux[`CM_VMEM_AW-1:0];
                @(negedge clk_pipeline);
                check_value({name, " char"}, s.exp_data, 32'(disp_char));
                @(posedge clk_pipeline);
                #2;
            end
            OP_PUSH: begin
                kbd_code  = s.aux[7:0];
                kbd_valid = 1'b1;
                @(posedge clk_pipeline);
                #2;
                kbd_valid = 1'b0;
            end
            OP_FLAGS: begin
                @(negedge clk_pipeline);
                check_value({name, " stall/overflow/ready"}, s.exp_data,
                            {29'h0, mem_stall, kbd_overflow, kbd_ready});
                @(posedge clk_pipeline);
                #2;
            end
            default: begin
                dmem = s.req;
                for (int k = 0; k < int'(s.aux); k++) begin
                    @(negedge clk_pipeline);
                    check_value($sformatf("%s cycle %0d", name, k), 32'h1, 32'(mem_stall));
                    @(posedge clk_pipeline);
                    #2;
                end
                dmem = '0;
                @(negedge clk_pipeline);
                check_value({name, " release"}, 32'h0, 32'(mem_stall));
                @(posedge clk_pipeline);
                #2;
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b0;
        dmem        = '0;
        instr_addr  = '0;
        kbd_valid   = 1'b0;
        kbd_code    = '0;
        disp_addr   = '0;
        n_checks    = 0;
        n_errors    = 0;
        cycle_limit = 0;
        void'($urandom(32'h2bc89de8));

        build_table();
        cycle_limit = 30 * steps.size() + 100;

        repeat (3) @(posedge clk_pipeline);
        #2;
        rst = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            run_step(names[i], steps[i]);
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_pipeline);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/cpu_mem_pkg.sv
verilog/region_decoder.sv
verilog/loader_ram.sv
verilog/text_mem_writer.sv
verilog/io_ctrl_regs.sv
verilog/scancode_queue.sv
verilog/cpu_mem_interface.sv
testbench/tb_cpu_mem_interface.sv
